//--- compile.f
+incdir+.
sdram_pkg.sv
sdram_fifo.sv
sdram_write.sv
sdram_read.sv
sdram.sv
sdram_model.sv
tb_sdram.sv

//--- tb_sdram.sv
`timescale 1ns/100ps
`default_nettype none
`include "sdram_config.svh"

module tb_sdram;

	import sdram_pkg::*;

	localparam int READY_TIMEOUT = 2000;
	localparam int FIFO_TIMEOUT  = 200;
	localparam int MODEL_TIMEOUT = 4;

	logic        clk;
	logic        rst;
	logic        wr_fifo_wr;
	logic [31:0] wr_fifo_data;
	logic [3:0]  wr_fifo_mask;
	logic        wr_fifo_full;
	logic        rd_fifo_rd;
	logic [31:0] rd_fifo_data;
	logic        rd_fifo_empty;
	logic        rd_fifo_reset;
	logic        write_en;
	logic        read_en;
	word_addr_t  address;
	logic        sdram_ready;
	logic        cke;
	logic        cs_n;
	logic        ras_n;
	logic        cas_n;
	logic        we_n;
	logic [11:0] addr;
	logic [1:0]  bank;
	wire  [15:0] data;
	logic [1:0]  data_mask;
	logic        mem_init_done;
	int          mem_refresh_count;
	logic        mem_fault;

	// every word written so far by word address
	logic [31:0] shadow [int];
	// words in the write fifo not yet bound to an address
	wr_word_t    pending_q [$];
	// expected read words in fifo order
	rd_word_t    expect_q [$];
	rd_word_t    popped;
	rd_word_t    expected;
	word_addr_t  addr_a;
	word_addr_t  addr_b;
	word_addr_t  addr_c;
	int          refresh_base;
	int          refresh_delta;
	int          cycles;

	sdram DUT (
		.clk           (clk),
		.rst           (rst),
		.wr_fifo_wr    (wr_fifo_wr),
		.wr_fifo_data  (wr_fifo_data),
		.wr_fifo_mask  (wr_fifo_mask),
		.wr_fifo_full  (wr_fifo_full),
		.rd_fifo_rd    (rd_fifo_rd),
		.rd_fifo_data  (rd_fifo_data),
		.rd_fifo_empty (rd_fifo_empty),
		.rd_fifo_reset (rd_fifo_reset),
		.write_en      (write_en),
		.read_en       (read_en),
		.address       (address),
		.sdram_ready   (sdram_ready),
		.cke           (cke),
		.cs_n          (cs_n),
		.ras_n         (ras_n),
		.cas_n         (cas_n),
		.we_n          (we_n),
		.addr          (addr),
		.bank          (bank),
		.data          (data),
		.data_mask     (data_mask)
	);

	sdram_model mem_model (
		.clk           (clk),
		.cke           (cke),
		.cs_n          (cs_n),
		.ras_n         (ras_n),
		.cas_n         (cas_n),
		.we_n          (we_n),
		.addr          (addr),
		.bank          (bank),
		.dq            (data),
		.dqm           (data_mask),
		.init_done     (mem_init_done),
		.refresh_count (mem_refresh_count),
		.fault         (mem_fault)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input rd_word_t got, input rd_word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got.data, exp.data);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// byte b keeps the old value when mask bit b is set
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] mask);
		logic [31:0] result;
		for (int b = 0; b < 4; b++) begin
			result[8*b +: 8] = mask[b] ? old_word[8*b +: 8] : new_word[8*b +: 8];
		end
		return result;
	endfunction

	// word address plus offset wraps at 22 bits
	function automatic int addr_key(input word_addr_t base, input int offset);
		logic [21:0] raw;
		raw = base;
		return int'(raw + 22'(offset));
	endfunction

	function automatic word_addr_t random_addr();
		return word_addr_t'(22'($urandom()));
	endfunction

	task automatic wait_ready(input string what);
		int n;
		n = 0;
		while (sdram_ready !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > READY_TIMEOUT) begin
				$display("timeout waiting for sdram_ready %s", what);
				abort_run();
			end
		end
	endtask

	task automatic push_word(input logic [31:0] word_data, input logic [3:0] mask);
		wr_word_t entry;
		int n;
		n = 0;
		while (wr_fifo_full !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > FIFO_TIMEOUT) begin
				$display("timeout waiting for room in the write fifo");
				abort_run();
			end
		end
		entry.mask   = mask;
		entry.data   = word_data;
		wr_fifo_wr   = 1'b1;
		wr_fifo_data = word_data;
		wr_fifo_mask = mask;
		pending_q.push_back(entry);
		@(negedge clk);
		wr_fifo_wr = 1'b0;
	endtask

	// drains everything pushed so far from start onwards
	task automatic write_pending(input word_addr_t start);
		int key;
		logic [31:0] old_word;
		wait_ready("before write");
		write_en = 1'b1;
		address  = start;
		for (int i = 0; i < pending_q.size(); i++) begin
			key      = addr_key(start, i);
			old_word = shadow.exists(key) ? shadow[key] : 32'hxxxx_xxxx;
			shadow[key] = merge_bytes(old_word, pending_q[i].data, pending_q[i].mask);
		end
		pending_q.delete();
		@(negedge clk);
		write_en = 1'b0;
		wait_ready("after write");
	endtask

	task automatic read_word(input word_addr_t at);
		int key;
		rd_word_t exp_word;
		wait_ready("before read");
		key           = addr_key(at, 0);
		exp_word.data = shadow.exists(key) ? shadow[key] : 32'hxxxx_xxxx;
		read_en       = 1'b1;
		address       = at;
		expect_q.push_back(exp_word);
		@(negedge clk);
		read_en = 1'b0;
		// ready comes back once the word is in the read fifo
		wait_ready("after read");
	endtask

	task automatic pop_read();
		int n;
		n = 0;
		while (rd_fifo_empty !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > FIFO_TIMEOUT) begin
				$display("timeout waiting for a word in the read fifo");
				abort_run();
			end
		end
		rd_fifo_rd = 1'b1;
		@(negedge clk);
		rd_fifo_rd = 1'b0;
	endtask

	// every pop is compared against the oldest expected word
	always @(posedge clk) begin
		if (rd_fifo_rd === 1'b1 && rd_fifo_empty === 1'b0) begin
			popped.data = rd_fifo_data;
			if (expect_q.size() == 0) begin
				$display("a word left the read fifo with nothing expected");
				abort_run();
			end else begin
				expected = expect_q.pop_front();
				check_word("rd_fifo_data", popped, expected);
			end
		end
	end

	always @(posedge clk) begin
		if (mem_fault === 1'b1) begin
			$display("the memory model saw a protocol violation");
			abort_run();
		end
	end

	initial begin
		rst           = 1'b1;
		wr_fifo_wr    = 1'b0;
		wr_fifo_data  = '0;
		wr_fifo_mask  = '0;
		rd_fifo_rd    = 1'b0;
		rd_fifo_reset = 1'b0;
		write_en      = 1'b0;
		read_en       = 1'b0;
		address       = '0;
		void'($urandom(65));

		// memory pins stay quiet through reset
		repeat (5) begin
			@(negedge clk);
			check_flag("cke", cke, 1'b0);
			check_flag("cs_n", cs_n, 1'b1);
			check_flag("sdram_ready", sdram_ready, 1'b0);
		end
		rst = 1'b0;
		@(negedge clk);
		check_flag("cke", cke, 1'b0);
		check_flag("cs_n", cs_n, 1'b1);
		check_flag("sdram_ready", sdram_ready, 1'b0);
		// both fifos come out of reset empty
		check_flag("wr_fifo_full", wr_fifo_full, 1'b0);
		check_flag("rd_fifo_empty", rd_fifo_empty, 1'b1);
		wait_ready("after init");
		// the memory registers load mode on the edge after ready rises
		cycles = 0;
		while (mem_init_done !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > MODEL_TIMEOUT) begin
				$display("init sequence not complete at the memory after sdram_ready");
				abort_run();
			end
		end

		// one word with all bytes written
		addr_a = random_addr();
		push_word($urandom(), 4'b0000);
		write_pending(addr_a);
		read_word(addr_a);
		pop_read();

		// masked write over a known old word
		addr_b = random_addr();
		push_word($urandom(), 4'b0000);
		write_pending(addr_b);
		push_word($urandom(), 4'($urandom_range(14, 1)));
		write_pending(addr_b);
		read_word(addr_b);
		pop_read();

		// sixteen words drained by one write_en
		addr_c = random_addr();
		for (int i = 0; i < 16; i++) begin
			push_word($urandom(), 4'b0000);
		end
		// sixteen entries fill the write fifo
		check_flag("wr_fifo_full", wr_fifo_full, 1'b1);
		write_pending(addr_c);
		for (int i = 0; i < 16; i++) begin
			read_word(word_addr_t'(addr_key(addr_c, i)));
			pop_read();
		end

		// refresh keeps running on its own through an idle stretch
		refresh_base = mem_refresh_count;
		repeat (5 * `SDRAM_T_REFRESH) @(negedge clk);
		refresh_delta = mem_refresh_count - refresh_base;
		if (refresh_delta < 4 || refresh_delta > 6) begin
			$display("[ERROR] refresh_count delta 0x%h outside 4 to 6", refresh_delta);
			abort_run();
		end

		// clear a read fifo holding two words
		read_word(addr_a);
		read_word(addr_b);
		check_flag("rd_fifo_empty", rd_fifo_empty, 1'b0);
		rd_fifo_reset = 1'b1;
		expect_q.delete();
		@(negedge clk);
		rd_fifo_reset = 1'b0;
		check_flag("rd_fifo_empty", rd_fifo_empty, 1'b1);
		read_word(word_addr_t'(addr_key(addr_c, 3)));
		pop_read();
		@(negedge clk);
		// the cleared fifo held only the last read word
		check_flag("rd_fifo_empty", rd_fifo_empty, 1'b1);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sdram_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "sdram_config.svh"

module sdram_model (
	input  logic        clk,
	input  logic        cke,
	input  logic        cs_n,
	input  logic        ras_n,
	input  logic        cas_n,
	input  logic        we_n,
	input  logic [11:0] addr,
	input  logic [1:0]  bank,
	inout  wire  [15:0] dq,
	input  logic [1:0]  dqm,
	output logic        init_done,
	output int          refresh_count,
	output logic        fault
);

	import sdram_pkg::*;

	// auto precharge is done this many cycles after the column command
	localparam int WR_CLOSE = 1 + `SDRAM_T_WR + `SDRAM_T_RP;
	localparam int RD_CLOSE = `SDRAM_CAS_LATENCY + 1 + `SDRAM_T_RP;

	// halfword storage keyed by {bank, row, halfword column}
	logic [15:0] mem [logic [22:0]];
	logic [11:0] open_row [4];
	logic        bank_open [4];
	int          close_cnt [4];
	longint      act_cycle [4];
	longint      cycle;
	int          init_step;
	sdram_cmd_e  cmd;
	// second beat of a write burst is due on the next edge
	logic        wr_second;
	logic [22:0] wr_key;
	longint      rd_cycle;
	logic [22:0] rd_key;
	logic [15:0] dq_drv;
	logic        dq_oe;

	assign dq = dq_oe ? dq_drv : 16'hzzzz;

	initial begin
		init_done     = 1'b0;
		refresh_count = 0;
		fault         = 1'b0;
		init_step     = 0;
		cycle         = 0;
		wr_second     = 1'b0;
		rd_cycle      = -100;
		dq_oe         = 1'b0;
		dq_drv        = '0;
		for (int b = 0; b < 4; b++) begin
			bank_open[b] = 1'b0;
			close_cnt[b] = 0;
			act_cycle[b] = 0;
		end
	end

	task automatic flag_violation(input string msg);
		$display("sdram model: %s at cycle %0d", msg, cycle);
		fault = 1'b1;
	endtask

	function automatic logic [15:0] read_beat(input logic [22:0] key);
		return mem.exists(key) ? mem[key] : 16'hxxxx;
	endfunction

	// a set dqm bit leaves that byte alone
	task automatic store_beat(input logic [22:0] key, input logic [15:0] value,
			input logic [1:0] mask);
		logic [15:0] cur;
		cur = read_beat(key);
		if (!mask[0]) begin
			cur[7:0] = value[7:0];
		end
		if (!mask[1]) begin
			cur[15:8] = value[15:8];
		end
		mem[key] = cur;
	endtask

	// precharge all, two refreshes, then the mode word
	task automatic track_init();
		case (cmd)
			CMD_NOP: begin
			end
			CMD_PRECHARGE: begin
				if (init_step == 0 && addr[10]) init_step = 1;
				else flag_violation("precharge all out of order during init");
			end
			CMD_AUTO_REFRESH: begin
				if (init_step == 1 || init_step == 2) init_step++;
				else flag_violation("auto refresh out of order during init");
			end
			CMD_LOAD_MODE: begin
				if (init_step == 3 && addr == 12'(`SDRAM_MODE_WORD)) init_done = 1'b1;
				else flag_violation("load mode out of order or with a wrong mode word");
			end
			default: flag_violation("command before init completes");
		endcase
	endtask

	task automatic run_command();
		logic [22:0] key;
		case (cmd)
			CMD_ACTIVE: begin
				if (bank_open[bank]) begin
					flag_violation("active to a bank that is already open");
				end else begin
					bank_open[bank] = 1'b1;
					open_row[bank]  = addr;
					act_cycle[bank] = cycle;
				end
			end
			CMD_WRITE, CMD_READ: begin
				if (!bank_open[bank]) begin
					flag_violation("read or write to a closed bank");
				end else if (cycle - act_cycle[bank] < `SDRAM_T_RCD) begin
					flag_violation("read or write sooner than tRCD after active");
				end else begin
					key = {bank, open_row[bank], addr[8:0]};
					if (addr[10]) begin
						close_cnt[bank] = (cmd == CMD_WRITE) ? WR_CLOSE : RD_CLOSE;
					end
					if (cmd == CMD_WRITE) begin
						// first beat comes with the command
						store_beat(key, dq, dqm);
						wr_key    = key + 23'd1;
						wr_second = 1'b1;
					end else begin
						rd_key   = key;
						rd_cycle = cycle;
					end
				end
			end
			CMD_AUTO_REFRESH: begin
				if (bank_open[0] || bank_open[1] || bank_open[2] || bank_open[3]) begin
					flag_violation("auto refresh with a bank open");
				end
				refresh_count++;
			end
			CMD_PRECHARGE: begin
				for (int b = 0; b < 4; b++) begin
					if (addr[10] || bank == 2'(b)) bank_open[b] = 1'b0;
				end
			end
			default: begin
			end
		endcase
	endtask

	always @(posedge clk) begin
		cycle++;
		// read data leaves cas latency edges after the command
		if (cycle == rd_cycle + `SDRAM_CAS_LATENCY - 1) begin
			dq_drv <= read_beat(rd_key);
			dq_oe  <= 1'b1;
		end else if (cycle == rd_cycle + `SDRAM_CAS_LATENCY) begin
			dq_drv <= read_beat(rd_key + 23'd1);
		end else if (cycle == rd_cycle + `SDRAM_CAS_LATENCY + 1) begin
			dq_oe <= 1'b0;
		end
		if (wr_second) begin
			store_beat(wr_key, dq, dqm);
			wr_second = 1'b0;
		end
		// auto precharge countdown per bank
		for (int b = 0; b < 4; b++) begin
			if (close_cnt[b] > 0) begin
				close_cnt[b]--;
				if (close_cnt[b] == 0) bank_open[b] = 1'b0;
			end
		end
		cmd = (cke === 1'b1 && cs_n === 1'b0) ? sdram_cmd_e'({ras_n, cas_n, we_n}) : CMD_NOP;
		if (!init_done) begin
			track_init();
		end else begin
			run_command();
		end
	end

endmodule

`default_nettype wire

//--- sdram.sv
`timescale 1ns/100ps
`default_nettype none
`include "sdram_config.svh"

module sdram (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wr_fifo_wr,
	input  logic [31:0]           wr_fifo_data,
	input  logic [3:0]            wr_fifo_mask,
	output logic                  wr_fifo_full,
	input  logic                  rd_fifo_rd,
	output logic [31:0]           rd_fifo_data,
	output logic                  rd_fifo_empty,
	input  logic                  rd_fifo_reset,
	input  logic                  write_en,
	input  logic                  read_en,
	input  sdram_pkg::word_addr_t address,
	output logic                  sdram_ready,
	output logic                  cke,
	output logic                  cs_n,
	output logic                  ras_n,
	output logic                  cas_n,
	output logic                  we_n,
	output logic [11:0]           addr,
	output logic [1:0]            bank,
	inout  wire  [15:0]           data,
	output logic [1:0]            data_mask
);

	import sdram_pkg::*;

	localparam int DLY_W = 16;
	localparam int REF_W = $clog2(`SDRAM_T_REFRESH);

	ctrl_state_e       state;
	logic [DLY_W-1:0]  delay;
	logic [REF_W-1:0]  ref_timer;
	logic              ref_pending;
	logic              init_done;
	sdram_cmd_e        init_cmd;
	logic [11:0]       init_addr;

	wr_word_t          wr_fifo_in;
	wr_word_t          wr_fifo_out;
	logic              wr_fifo_empty;
	logic              wr_fifo_pop;
	rd_word_t          rd_word;
	rd_word_t          rd_fifo_out;
	logic              rd_word_valid;
	logic              rd_fifo_full;
	logic              rd_fifo_clr;

	logic              wr_start;
	logic              wr_busy;
	sdram_cmd_e        wr_cmd;
	logic [11:0]       wr_addr;
	logic [1:0]        wr_bank;
	logic [1:0]        wr_dqm;
	logic [15:0]       wr_dq;
	logic              wr_oe;
	logic              rd_start;
	logic              rd_busy;
	sdram_cmd_e        rd_cmd;
	logic [11:0]       rd_addr;
	logic [1:0]        rd_bank;
	logic [1:0]        rd_dqm;

	sdram_cmd_e        cmd_q;
	logic [15:0]       dq_out_q;
	logic              dq_oe_q;

	assign wr_fifo_in.mask = wr_fifo_mask;
	assign wr_fifo_in.data = wr_fifo_data;
	assign rd_fifo_data    = rd_fifo_out.data;
	assign rd_fifo_clr     = rst || rd_fifo_reset;

	assign init_done = (state inside {ST_READY, ST_WRITE, ST_READ});
	// idle, no refresh owed, room for a read result
	assign sdram_ready = (state == ST_READY) && (delay == '0) && !ref_pending && !rd_fifo_full;
	// write wins when both pulses come together
	assign wr_start = sdram_ready && write_en;
	assign rd_start = sdram_ready && read_en && !write_en;

	assign {ras_n, cas_n, we_n} = cmd_q;
	// the bus is released except during write beats
	assign data = dq_oe_q ? dq_out_q : 16'hzzzz;

	sdram_fifo #(.payload_t(wr_word_t)) u_wr_fifo (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_fifo_wr),
		.rd_en    (wr_fifo_pop),
		.data_in  (wr_fifo_in),
		.data_out (wr_fifo_out),
		.full     (wr_fifo_full),
		.empty    (wr_fifo_empty)
	);

	sdram_fifo #(.payload_t(rd_word_t)) u_rd_fifo (
		.clk      (clk),
		.rst      (rd_fifo_clr),
		.wr_en    (rd_word_valid),
		.rd_en    (rd_fifo_rd),
		.data_in  (rd_word),
		.data_out (rd_fifo_out),
		.full     (rd_fifo_full),
		.empty    (rd_fifo_empty)
	);

	sdram_write u_write (
		.clk        (clk),
		.rst        (rst),
		.start      (wr_start),
		.start_addr (address),
		.fifo_word  (wr_fifo_out),
		.fifo_empty (wr_fifo_empty),
		.fifo_pop   (wr_fifo_pop),
		.busy       (wr_busy),
		.cmd        (wr_cmd),
		.addr       (wr_addr),
		.bank       (wr_bank),
		.dqm        (wr_dqm),
		.dq_out     (wr_dq),
		.dq_oe      (wr_oe)
	);

	// read data comes straight off the pins
	sdram_read u_read (
		.clk        (clk),
		.rst        (rst),
		.start      (rd_start),
		.start_addr (address),
		.dq_in      (data),
		.busy       (rd_busy),
		.cmd        (rd_cmd),
		.addr       (rd_addr),
		.bank       (rd_bank),
		.dqm        (rd_dqm),
		.word       (rd_word),
		.word_valid (rd_word_valid)
	);

	// init sequence, refresh service and arbitration share one delay counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_RESET;
			delay       <= DLY_W'(`SDRAM_T_PLL);
			cke         <= 1'b0;
			cs_n        <= 1'b1;
			init_cmd    <= CMD_NOP;
			ref_pending <= 1'b0;
		end else begin
			init_cmd <= CMD_NOP;
			if (delay != '0) begin
				delay <= delay - 1'b1;
			end else begin
				case (state)
					ST_RESET: begin
						cke   <= 1'b1;
						delay <= DLY_W'(`SDRAM_T_PLL);
						state <= ST_CKE_HIGH;
					end
					ST_CKE_HIGH: begin
						cs_n  <= 1'b0;
						state <= ST_PRECHARGE;
					end
					ST_PRECHARGE: begin
						init_cmd <= CMD_PRECHARGE;
						delay    <= DLY_W'(`SDRAM_T_RP - 1);
						state    <= ST_REFRESH1;
					end
					ST_REFRESH1: begin
						init_cmd <= CMD_AUTO_REFRESH;
						delay    <= DLY_W'(`SDRAM_T_RFC - 1);
						state    <= ST_REFRESH2;
					end
					ST_REFRESH2: begin
						init_cmd <= CMD_AUTO_REFRESH;
						delay    <= DLY_W'(`SDRAM_T_RFC - 1);
						state    <= ST_LOAD_MODE;
					end
					ST_LOAD_MODE: begin
						init_cmd <= CMD_LOAD_MODE;
						delay    <= DLY_W'(`SDRAM_T_MRD - 1);
						state    <= ST_READY;
					end
					ST_READY: begin
						// refresh only between accesses, all banks are closed here
						if (ref_pending) begin
							init_cmd    <= CMD_AUTO_REFRESH;
							delay       <= DLY_W'(`SDRAM_T_RFC - 1);
							ref_pending <= 1'b0;
						end else if (wr_start) begin
							state <= ST_WRITE;
						end else if (rd_start) begin
							state <= ST_READ;
						end
					end
					ST_WRITE: begin
						if (!wr_busy) begin
							state <= ST_READY;
						end
					end
					ST_READ: begin
						if (!rd_busy) begin
							state <= ST_READY;
						end
					end
					default: state <= ST_RESET;
				endcase
			end
			// a new request overrides the clear of the one just served
			if (init_done && ref_timer == '0) begin
				ref_pending <= 1'b1;
			end
		end
	end

	// A10 for precharge all, the mode word for load mode
	always_ff @(posedge clk) begin
		if (delay == '0 && state == ST_PRECHARGE) begin
			init_addr <= 12'h400;
		end else if (delay == '0 && state == ST_LOAD_MODE) begin
			init_addr <= 12'(`SDRAM_MODE_WORD);
		end
	end

	// refresh interval counts only once the memory is initialized
	always_ff @(posedge clk) begin
		if (rst || !init_done || ref_timer == '0) begin
			ref_timer <= REF_W'(`SDRAM_T_REFRESH - 1);
		end else begin
			ref_timer <= ref_timer - 1'b1;
		end
	end

	// pin register, the owner is picked by the controller state
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_q   <= CMD_NOP;
			dq_oe_q <= 1'b0;
		end else begin
			case (state)
				ST_WRITE: begin
					cmd_q   <= wr_cmd;
					dq_oe_q <= wr_oe;
				end
				ST_READ: begin
					cmd_q   <= rd_cmd;
					dq_oe_q <= 1'b0;
				end
				default: begin
					cmd_q   <= init_cmd;
					dq_oe_q <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		dq_out_q <= wr_dq;
		case (state)
			ST_WRITE: begin
				addr      <= wr_addr;
				bank      <= wr_bank;
				data_mask <= wr_dqm;
			end
			ST_READ: begin
				addr      <= rd_addr;
				bank      <= rd_bank;
				data_mask <= rd_dqm;
			end
			default: begin
				addr      <= init_addr;
				bank      <= 2'b00;
				data_mask <= 2'b11;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- sdram_read.sv
`timescale 1ns/100ps
`default_nettype none
`include "sdram_config.svh"

module sdram_read (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  sdram_pkg::word_addr_t  start_addr,
	input  logic [15:0]            dq_in,
	output logic                   busy,
	output sdram_pkg::sdram_cmd_e  cmd,
	output logic [11:0]            addr,
	output logic [1:0]             bank,
	output logic [1:0]             dqm,
	output sdram_pkg::rd_word_t    word,
	output logic                   word_valid
);

	import sdram_pkg::*;

	typedef enum logic [2:0] {
		R_IDLE,
		R_RCD,
		R_CAS,
		R_HIGH,
		R_RP
	} rd_state_e;

	rd_state_e   state;
	logic [3:0]  cnt;
	logic [7:0]  col_q;
	logic [15:0] low_q;

	assign busy = (state != R_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= R_IDLE;
			cmd        <= CMD_NOP;
			cnt        <= '0;
			word_valid <= 1'b0;
		end else begin
			cmd        <= CMD_NOP;
			word_valid <= 1'b0;
			case (state)
				R_IDLE: begin
					// activate goes out right away
					if (start) begin
						cmd   <= CMD_ACTIVE;
						cnt   <= 4'(`SDRAM_T_RCD - 1);
						state <= R_RCD;
					end
				end
				R_RCD: begin
					if (cnt == '0) begin
						cmd   <= CMD_READ;
						// cas latency plus one cycle for the output register in the top
						cnt   <= 4'(`SDRAM_CAS_LATENCY + 1);
						state <= R_CAS;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				R_CAS: begin
					if (cnt == '0) begin
						state <= R_HIGH;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				R_HIGH: begin
					word_valid <= 1'b1;
					cnt        <= 4'(`SDRAM_T_RP - 1);
					state      <= R_RP;
				end
				R_RP: begin
					// auto precharge runs out before the bank is used again
					if (cnt == '0) begin
						state <= R_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		// dq enabled from activate to the end of the access
		dqm <= (state == R_IDLE && !start) ? 2'b11 : 2'b00;
		if (state == R_IDLE && start) begin
			addr  <= start_addr.row;
			bank  <= start_addr.bank;
			col_q <= start_addr.col;
		end else if (state == R_RCD) begin
			addr <= {3'b010, col_q, 1'b0};
		end
		// low beat first, then the high beat completes the word
		if (state == R_CAS && cnt == '0) begin
			low_q <= dq_in;
		end
		if (state == R_HIGH) begin
			word.data <= {dq_in, low_q};
		end
	end

endmodule

`default_nettype wire

//--- sdram_write.sv
`timescale 1ns/100ps
`default_nettype none
`include "sdram_config.svh"

module sdram_write (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  sdram_pkg::word_addr_t  start_addr,
	input  sdram_pkg::wr_word_t    fifo_word,
	input  logic                   fifo_empty,
	output logic                   fifo_pop,
	output logic                   busy,
	output sdram_pkg::sdram_cmd_e  cmd,
	output logic [11:0]            addr,
	output logic [1:0]             bank,
	output logic [1:0]             dqm,
	output logic [15:0]            dq_out,
	output logic                   dq_oe
);

	import sdram_pkg::*;

	typedef enum logic [2:0] {
		W_IDLE,
		W_CHECK,
		W_RCD,
		W_HIGH,
		W_RECOVER
	} wr_state_e;

	wr_state_e  state;
	word_addr_t cur_addr;
	logic [3:0] cnt;

	assign busy     = (state != W_IDLE);
	// head word leaves the fifo with its second beat
	assign fifo_pop = (state == W_HIGH);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= W_IDLE;
			cmd   <= CMD_NOP;
			dq_oe <= 1'b0;
			cnt   <= '0;
		end else begin
			cmd   <= CMD_NOP;
			dq_oe <= 1'b0;
			case (state)
				W_IDLE: begin
					if (start) begin
						state <= W_CHECK;
					end
				end
				W_CHECK: begin
					// nothing left to drain ends the run
					if (fifo_empty) begin
						state <= W_IDLE;
					end else begin
						cmd   <= CMD_ACTIVE;
						cnt   <= 4'(`SDRAM_T_RCD - 1);
						state <= W_RCD;
					end
				end
				W_RCD: begin
					if (cnt == '0) begin
						// write with auto precharge, first beat goes with the command
						cmd   <= CMD_WRITE;
						dq_oe <= 1'b1;
						state <= W_HIGH;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				W_HIGH: begin
					dq_oe <= 1'b1;
					// the CHECK cycle supplies the last recovery cycle
					cnt   <= 4'(`SDRAM_T_WR + `SDRAM_T_RP - 2);
					state <= W_RECOVER;
				end
				W_RECOVER: begin
					if (cnt == '0) begin
						state <= W_CHECK;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// address, mask and data lanes follow the state
	always_ff @(posedge clk) begin
		dqm <= 2'b11;
		if (state == W_IDLE && start) begin
			cur_addr <= start_addr;
		end else if (state == W_RECOVER && cnt == '0) begin
			cur_addr <= word_addr_t'(cur_addr + 22'd1);
		end
		case (state)
			W_CHECK: begin
				addr <= cur_addr.row;
				bank <= cur_addr.bank;
			end
			W_RCD: begin
				// A10 set for auto precharge, halfword column in A8:A0
				addr   <= {3'b010, cur_addr.col, 1'b0};
				dq_out <= fifo_word.data[15:0];
				if (cnt == '0) begin
					dqm <= fifo_word.mask[1:0];
				end
			end
			W_HIGH: begin
				dq_out <= fifo_word.data[31:16];
				dqm    <= fifo_word.mask[3:2];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- sdram_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "sdram_config.svh"

module sdram_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int ADDR_W = `SDRAM_FIFO_ADDR_W
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_en,
	input  logic     rd_en,
	input  payload_t data_in,
	output payload_t data_out,
	output logic     full,
	output logic     empty
);

	localparam int DEPTH = 2 ** ADDR_W;

	payload_t          mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	// one extra bit so a full buffer is distinct from empty
	logic [ADDR_W:0]   count;
	logic              do_wr;
	logic              do_rd;

	assign full     = (count == (ADDR_W + 1)'(DEPTH));
	assign empty    = (count == '0);
	// blocked requests are dropped
	assign do_wr    = wr_en && !full;
	assign do_rd    = rd_en && !empty;
	// head entry straight from the array, no read latency
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leave the count alone
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sdram_pkg.sv
`default_nettype none

package sdram_pkg;

	// {ras_n, cas_n, we_n} with cs_n low
	typedef enum logic [2:0] {
		CMD_LOAD_MODE    = 3'b000,
		CMD_AUTO_REFRESH = 3'b001,
		CMD_PRECHARGE    = 3'b010,
		CMD_ACTIVE       = 3'b011,
		CMD_WRITE        = 3'b100,
		CMD_READ         = 3'b101,
		CMD_NOP          = 3'b111
	} sdram_cmd_e;

	// top level controller state
	typedef enum logic [3:0] {
		ST_RESET,
		ST_CKE_HIGH,
		ST_PRECHARGE,
		ST_REFRESH1,
		ST_REFRESH2,
		ST_LOAD_MODE,
		ST_READY,
		ST_WRITE,
		ST_READ
	} ctrl_state_e;

	// write fifo entry, a set mask bit keeps that byte unwritten
	typedef struct packed {
		logic [3:0]  mask;
		logic [31:0] data;
	} wr_word_t;

	// read fifo entry
	typedef struct packed {
		logic [31:0] data;
	} rd_word_t;

	// host word address
	typedef struct packed {
		logic [1:0]  bank;
		logic [11:0] row;
		logic [7:0]  col;
	} word_addr_t;

endpackage

`default_nettype wire

//--- sdram_config.svh
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// all timing values count clk cycles
// power-up wait, used once with cke low and once with cke high
`define SDRAM_T_PLL 50

// precharge to next activate
`define SDRAM_T_RP 1

// auto refresh cycle time
`define SDRAM_T_RFC 7

// load mode register to first command
`define SDRAM_T_MRD 2

// activate to read or write
`define SDRAM_T_RCD 2

// last write beat to start of auto precharge
`define SDRAM_T_WR 2

// spacing of refresh requests once initialized
`define SDRAM_T_REFRESH 400

// mode register: burst length 2, sequential, cas latency 2
`define SDRAM_MODE_WORD 12'h021
`define SDRAM_CAS_LATENCY 2

// log2 of the fifo depth
`define SDRAM_FIFO_ADDR_W 4

`endif
